/* mshr_cfg_pkg.sv */
`default_nettype none

package mshr_cfg_pkg;

  // queue geometry
  localparam int mshr_depth = 8;
  localparam int mshr_lanes = 2;
  localparam int idx_width  = $clog2(mshr_depth);

  // bus widths
  localparam int addr_width = 32;
  localparam int data_width = 64;
  localparam int tag_width  = 4;

  // position in the circular entry table
  typedef logic [idx_width-1:0] mshr_idx_t;

  // cache line address and line payload
  typedef logic [addr_width-1:0] mshr_addr_t;
  typedef logic [data_width-1:0] mshr_data_t;

  // split-transaction tag where zero means no transaction
  typedef logic [tag_width-1:0] mem_tag_t;

endpackage

`default_nettype wire

/* mshr_types_pkg.sv */
`default_nettype none

package mshr_types_pkg;

  import mshr_cfg_pkg::*;

  // memory bus command
  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } bus_command_e;

  // per-entry progress through memory
  typedef enum logic [1:0] {
    waiting     = 2'd0,
    in_progress = 2'd1,
    done        = 2'd2
  } entry_state_e;

  typedef struct packed {
    logic         valid;
    mshr_addr_t   addr;
    mshr_data_t   data;
    bus_command_e command;
    entry_state_e state;
    mem_tag_t     tag;
  } mshr_entry_t;

  // one miss lane from the cache
  typedef struct packed {
    logic         en;
    mshr_addr_t   addr;
    mshr_data_t   data;
    bus_command_e command;
  } miss_req_t;

  typedef struct packed {
    bus_command_e command;
    mshr_addr_t   addr;
    mshr_data_t   data;
  } mem_req_t;

  // rsp_tag accepts the current request, cmp_tag names a finished load
  typedef struct packed {
    mem_tag_t   rsp_tag;
    mem_tag_t   cmp_tag;
    mshr_data_t data;
  } mem_rsp_t;

  typedef struct packed {
    logic       valid;
    mshr_addr_t addr;
    mshr_data_t data;
  } fill_t;

  typedef struct packed {
    logic       en;
    mshr_addr_t addr;
  } search_req_t;

  typedef struct packed {
    logic       hit;
    logic       forward;
    mshr_data_t data;
  } search_rsp_t;

  // table write produced by the allocator
  typedef struct packed {
    logic        en;
    mshr_idx_t   idx;
    mshr_entry_t entry;
  } alloc_write_t;

endpackage

`default_nettype wire

/* mshr_entry_table.sv */
`timescale 1ns/1ps
`default_nettype none

module mshr_entry_table (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  mshr_types_pkg::alloc_write_t [mshr_cfg_pkg::mshr_lanes-1:0] alloc_wr,
  input  logic                                                    issue_accept,
  input  mshr_cfg_pkg::mshr_idx_t                                 issue_idx,
  input  mshr_types_pkg::mem_rsp_t                                mem_rsp,
  input  logic                                                    retire_clear,
  input  mshr_cfg_pkg::mshr_idx_t                                 retire_idx,
  output mshr_types_pkg::mshr_entry_t [mshr_cfg_pkg::mshr_depth-1:0] entries,
  output logic [mshr_cfg_pkg::mshr_depth-1:0]                     valid_vec
);

  import mshr_cfg_pkg::*;
  import mshr_types_pkg::*;

  mshr_entry_t [mshr_depth-1:0] entries_next;

  always_comb begin
    for (int i = 0; i < mshr_depth; i++) begin
      valid_vec[i] = entries[i].valid;
    end
  end

  always_comb begin
    entries_next = entries;

    // load data comes back in any order and is matched by tag
    for (int i = 0; i < mshr_depth; i++) begin
      if (entries[i].valid && entries[i].state == in_progress &&
          mem_rsp.cmp_tag != '0 && entries[i].tag == mem_rsp.cmp_tag) begin
        entries_next[i].state = done;
        entries_next[i].data  = mem_rsp.data;
      end
    end

    // request taken by memory
    if (issue_accept) begin
      if (entries[issue_idx].command == bus_load) begin
        entries_next[issue_idx].state = in_progress;
        entries_next[issue_idx].tag   = mem_rsp.rsp_tag;
      end else begin
        // evictions need no reply
        entries_next[issue_idx].state = done;
      end
    end

    if (retire_clear) begin
      entries_next[retire_idx].valid = 1'b0;
    end

    // new misses land in free slots only
    for (int l = 0; l < mshr_lanes; l++) begin
      if (alloc_wr[l].en) begin
        entries_next[alloc_wr[l].idx] = alloc_wr[l].entry;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < mshr_depth; i++) begin
        entries[i].valid <= 1'b0;
        entries[i].state <= waiting;
      end
    end else begin
      entries <= entries_next;
    end
  end

endmodule

`default_nettype wire

/* mshr_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module mshr_alloc (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  mshr_types_pkg::miss_req_t [mshr_cfg_pkg::mshr_lanes-1:0]  miss,
  input  logic [mshr_cfg_pkg::mshr_depth-1:0]                     valid_vec,
  output mshr_types_pkg::alloc_write_t [mshr_cfg_pkg::mshr_lanes-1:0] alloc_wr,
  output logic                                                    ready
);

  import mshr_cfg_pkg::*;
  import mshr_types_pkg::*;

  mshr_idx_t tail_q;
  mshr_idx_t offset;
  mshr_idx_t slot;

  function automatic mshr_entry_t new_entry(input miss_req_t m);
    mshr_entry_t e;
    e.valid   = 1'b1;
    e.addr    = m.addr;
    e.data    = m.data;
    e.command = m.command;
    e.state   = waiting;
    e.tag     = '0;
    return e;
  endfunction

  // pack enabled lanes into consecutive slots from the tail
  always_comb begin
    offset = '0;
    for (int l = 0; l < mshr_lanes; l++) begin
      alloc_wr[l].en    = miss[l].en;
      alloc_wr[l].idx   = tail_q + offset;
      alloc_wr[l].entry = new_entry(miss[l]);
      if (miss[l].en) begin
        offset = offset + 1'b1;
      end
    end
  end

  // room for a full set of lanes at the tail
  always_comb begin
    ready = 1'b1;
    for (int l = 0; l < mshr_lanes; l++) begin
      slot = tail_q + mshr_idx_t'(l);
      if (valid_vec[slot]) begin
        ready = 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tail_q <= '0;
    end else begin
      tail_q <= tail_q + offset;
    end
  end

  // the cache must hold its misses while the queue is full
  a_miss_needs_ready: assert property (
    @(posedge clock) disable iff (reset)
    (|{miss[1].en, miss[0].en}) |-> ready
  ) else $error("miss enabled while ready is low");

endmodule

`default_nettype wire

/* mshr_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module mshr_issue (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  mshr_types_pkg::mshr_entry_t [mshr_cfg_pkg::mshr_depth-1:0] entries,
  input  mshr_types_pkg::mem_rsp_t                                mem_rsp,
  output mshr_types_pkg::mem_req_t                                mem_req,
  output logic                                                    issue_accept,
  output mshr_cfg_pkg::mshr_idx_t                                 issue_idx
);

  import mshr_cfg_pkg::*;
  import mshr_types_pkg::*;

  mshr_idx_t   head_q;
  mshr_entry_t head_entry;
  logic        req_valid;

  assign head_entry = entries[head_q];

  // oldest entry not yet sent
  assign req_valid = head_entry.valid && head_entry.state == waiting;

  assign mem_req.command = req_valid ? head_entry.command : bus_none;
  assign mem_req.addr    = head_entry.addr;
  assign mem_req.data    = head_entry.data;

  // nonzero response tag means memory took it
  assign issue_accept = req_valid && mem_rsp.rsp_tag != '0;
  assign issue_idx    = head_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q <= '0;
    end else if (issue_accept) begin
      head_q <= head_q + 1'b1;
    end
  end

  // stalled request must not change under memory
  a_req_stable: assert property (
    @(posedge clock) disable iff (reset)
    (mem_req.command != bus_none && mem_rsp.rsp_tag == '0) |=> $stable(mem_req)
  ) else $error("mem_req changed while stalled");

endmodule

`default_nettype wire

/* mshr_search.sv */
`timescale 1ns/1ps
`default_nettype none

module mshr_search (
  input  mshr_types_pkg::mshr_entry_t [mshr_cfg_pkg::mshr_depth-1:0] entries,
  input  mshr_cfg_pkg::mshr_idx_t                                 retire_idx,
  input  mshr_types_pkg::search_req_t                             search_req,
  output mshr_types_pkg::search_rsp_t                             search_rsp
);

  import mshr_cfg_pkg::*;
  import mshr_types_pkg::*;

  mshr_idx_t idx;
  mshr_idx_t oldest;
  logic      found;

  // walk from the writeback head so the first match is the oldest
  always_comb begin
    found  = 1'b0;
    oldest = retire_idx;
    for (int i = 0; i < mshr_depth; i++) begin
      idx = retire_idx + mshr_idx_t'(i);
      if (!found && entries[idx].valid && entries[idx].addr == search_req.addr) begin
        found  = 1'b1;
        oldest = idx;
      end
    end
  end

  always_comb begin
    search_rsp.hit     = search_req.en && found;
    // a pending eviction still holds the newest copy of the line
    search_rsp.forward = search_rsp.hit && entries[oldest].command == bus_store;
    search_rsp.data    = search_rsp.forward ? entries[oldest].data : '0;
  end

endmodule

`default_nettype wire

/* mshr_retire.sv */
`timescale 1ns/1ps
`default_nettype none

module mshr_retire (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  mshr_types_pkg::mshr_entry_t [mshr_cfg_pkg::mshr_depth-1:0] entries,
  input  logic                                                    fill_accept,
  output mshr_types_pkg::fill_t                                   fill,
  output logic                                                    retire_clear,
  output mshr_cfg_pkg::mshr_idx_t                                 retire_idx
);

  import mshr_cfg_pkg::*;
  import mshr_types_pkg::*;

  mshr_idx_t   wb_q;
  mshr_entry_t wb_entry;
  logic        wb_done;

  assign wb_entry = entries[wb_q];
  assign wb_done  = wb_entry.valid && wb_entry.state == done;

  // only loads return a line to the cache
  assign fill.valid = wb_done && wb_entry.command == bus_load;
  assign fill.addr  = wb_entry.addr;
  assign fill.data  = wb_entry.data;

  // evictions leave without waiting on the cache
  assign retire_clear = wb_done && (wb_entry.command != bus_load || fill_accept);
  assign retire_idx   = wb_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_q <= '0;
    end else if (retire_clear) begin
      wb_q <= wb_q + 1'b1;
    end
  end

  a_fill_stable: assert property (
    @(posedge clock) disable iff (reset)
    (fill.valid && !fill_accept) |=> (fill.valid && $stable(fill))
  ) else $error("fill dropped or changed before accept");

endmodule

`default_nettype wire

/* mshr_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mshr_top (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  mshr_types_pkg::miss_req_t [mshr_cfg_pkg::mshr_lanes-1:0]  miss,
  input  mshr_types_pkg::mem_rsp_t                                mem_rsp,
  input  mshr_types_pkg::search_req_t                             search_req,
  input  logic                                                    fill_accept,
  output logic                                                    ready,
  output mshr_types_pkg::mem_req_t                                mem_req,
  output mshr_types_pkg::fill_t                                   fill,
  output mshr_types_pkg::search_rsp_t                             search_rsp,
  output logic                                                    empty
);

  import mshr_cfg_pkg::*;
  import mshr_types_pkg::*;

  mshr_entry_t [mshr_depth-1:0]  entries;
  logic [mshr_depth-1:0]         valid_vec;
  alloc_write_t [mshr_lanes-1:0] alloc_wr;
  logic                          issue_accept;
  mshr_idx_t                     issue_idx;
  logic                          retire_clear;
  mshr_idx_t                     retire_idx;

  assign empty = ~|valid_vec;

  mshr_entry_table u_table (
    .clock        (clock),
    .reset        (reset),
    .alloc_wr     (alloc_wr),
    .issue_accept (issue_accept),
    .issue_idx    (issue_idx),
    .mem_rsp      (mem_rsp),
    .retire_clear (retire_clear),
    .retire_idx   (retire_idx),
    .entries      (entries),
    .valid_vec    (valid_vec)
  );

  // miss lanes into table writes
  mshr_alloc u_alloc (
    .clock     (clock),
    .reset     (reset),
    .miss      (miss),
    .valid_vec (valid_vec),
    .alloc_wr  (alloc_wr),
    .ready     (ready)
  );

  mshr_issue u_issue (
    .clock        (clock),
    .reset        (reset),
    .entries      (entries),
    .mem_rsp      (mem_rsp),
    .mem_req      (mem_req),
    .issue_accept (issue_accept),
    .issue_idx    (issue_idx)
  );

  // fills back to the cache
  mshr_retire u_retire (
    .clock        (clock),
    .reset        (reset),
    .entries      (entries),
    .fill_accept  (fill_accept),
    .fill         (fill),
    .retire_clear (retire_clear),
    .retire_idx   (retire_idx)
  );

  mshr_search u_search (
    .entries    (entries),
    .retire_idx (retire_idx),
    .search_req (search_req),
    .search_rsp (search_rsp)
  );

endmodule

`default_nettype wire

/* tb_mshr_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mshr_model (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  mshr_types_pkg::miss_req_t [mshr_cfg_pkg::mshr_lanes-1:0]  miss,
  input  mshr_types_pkg::mem_req_t                                mem_req,
  input  logic                                                    fill_accept,
  input  mshr_types_pkg::search_req_t                             search_req,
  output mshr_types_pkg::mem_rsp_t                                mem_rsp,
  output mshr_types_pkg::mem_req_t                                exp_req,
  output mshr_types_pkg::fill_t                                   exp_fill,
  output mshr_types_pkg::search_rsp_t                             exp_search,
  output logic                                                    exp_ready,
  output logic                                                    exp_empty
);

  import mshr_cfg_pkg::*;
  import mshr_types_pkg::*;

  localparam int         ring     = 16;
  localparam mshr_data_t load_key = 64'h5a5a_c3c3_0f0f_9696;

  // reference queue indexed by allocation sequence number
  mshr_addr_t   q_addr [ring];
  mshr_data_t   q_data [ring];
  bus_command_e q_cmd  [ring];
  mem_tag_t     q_tag  [ring];
  logic         q_done [ring];
  logic         q_pend [ring];

  int       alloc_cnt  = 0;
  int       issue_cnt  = 0;
  int       retire_cnt = 0;
  mem_tag_t next_tag   = 4'd1;
  logic     s_found;
  int       s_slot;

  function automatic mshr_data_t line_value(input mshr_addr_t a);
    return mshr_data_t'(a) ^ load_key;
  endfunction

  // one random outstanding load may come back this cycle
  task automatic offer_completion();
    int count;
    int pick;
    int slot;
    count = 0;
    for (int n = retire_cnt; n < issue_cnt; n++) begin
      if (q_pend[n % ring]) count++;
    end
    if (count != 0 && ($urandom % 3) == 0) begin
      pick = $urandom % count;
      for (int n = retire_cnt; n < issue_cnt; n++) begin
        slot = n % ring;
        if (q_pend[slot]) begin
          if (pick == 0) begin
            mem_rsp.cmp_tag = q_tag[slot];
            mem_rsp.data    = line_value(q_addr[slot]);
          end
          pick--;
        end
      end
    end
  endtask

  task automatic update_state();
    int r;
    int s;
    r = retire_cnt % ring;
    // retirement sees the entry states from before this edge
    if (retire_cnt < alloc_cnt && q_done[r]) begin
      if (q_cmd[r] == bus_store || fill_accept) retire_cnt++;
    end
    if (mem_rsp.cmp_tag != '0) begin
      for (int n = retire_cnt; n < issue_cnt; n++) begin
        s = n % ring;
        if (q_pend[s] && q_tag[s] == mem_rsp.cmp_tag) begin
          q_pend[s] = 1'b0;
          q_done[s] = 1'b1;
        end
      end
    end
    if (mem_rsp.rsp_tag != '0 && issue_cnt < alloc_cnt) begin
      s = issue_cnt % ring;
      q_tag[s] = mem_rsp.rsp_tag;
      // evictions finish on accept
      if (q_cmd[s] == bus_load) q_pend[s] = 1'b1;
      else q_done[s] = 1'b1;
      issue_cnt++;
      next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
    end
    for (int l = 0; l < mshr_lanes; l++) begin
      if (miss[l].en) begin
        s = alloc_cnt % ring;
        q_addr[s] = miss[l].addr;
        q_data[s] = miss[l].data;
        q_cmd[s]  = miss[l].command;
        q_tag[s]  = '0;
        q_done[s] = 1'b0;
        q_pend[s] = 1'b0;
        alloc_cnt++;
      end
    end
  endtask

  // memory side driven on the falling edge
  initial begin
    mem_rsp = '0;
    forever begin
      @(negedge clock);
      mem_rsp = '0;
      if (!reset) begin
        if (mem_req.command != bus_none && ($urandom % 3) != 0) mem_rsp.rsp_tag = next_tag;
        offer_completion();
      end
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      alloc_cnt  = 0;
      issue_cnt  = 0;
      retire_cnt = 0;
      next_tag   = 4'd1;
    end else begin
      update_state();
    end
  end

  always_comb begin
    exp_req   = '0;
    exp_fill  = '0;
    exp_ready = (alloc_cnt - retire_cnt) <= (mshr_depth - mshr_lanes);
    exp_empty = alloc_cnt == retire_cnt;
    if (issue_cnt < alloc_cnt) begin
      exp_req.command = q_cmd[issue_cnt % ring];
      exp_req.addr    = q_addr[issue_cnt % ring];
      exp_req.data    = q_data[issue_cnt % ring];
    end
    if (retire_cnt < alloc_cnt && q_done[retire_cnt % ring] &&
        q_cmd[retire_cnt % ring] == bus_load) begin
      exp_fill.valid = 1'b1;
      exp_fill.addr  = q_addr[retire_cnt % ring];
      exp_fill.data  = line_value(q_addr[retire_cnt % ring]);
    end
  end

  // oldest live entry with the searched line
  always_comb begin
    exp_search = '0;
    s_found    = 1'b0;
    for (int n = 0; n < mshr_depth; n++) begin
      s_slot = (retire_cnt + n) % ring;
      if (!s_found && search_req.en && retire_cnt + n < alloc_cnt &&
          q_addr[s_slot] == search_req.addr) begin
        s_found        = 1'b1;
        exp_search.hit = 1'b1;
        if (q_cmd[s_slot] == bus_store) begin
          exp_search.forward = 1'b1;
          exp_search.data    = q_data[s_slot];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb_mshr.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mshr;

  import mshr_cfg_pkg::*;
  import mshr_types_pkg::*;

  localparam int period         = 100;
  localparam int reset_cycles   = 4;
  localparam int traffic_cycles = 2000;
  localparam int stall_cycles   = 200;
  localparam int drain_limit    = 400;
  localparam int total_cycles   = reset_cycles + traffic_cycles + stall_cycles + drain_limit;

  logic                       clock;
  logic                       reset;
  miss_req_t [mshr_lanes-1:0] miss;
  mem_rsp_t                   mem_rsp;
  search_req_t                search_req;
  logic                       fill_accept;
  logic                       ready;
  mem_req_t                   mem_req;
  fill_t                      fill;
  search_rsp_t                search_rsp;
  logic                       empty;
  mem_req_t                   exp_req;
  fill_t                      exp_fill;
  search_rsp_t                exp_search;
  logic                       exp_ready;
  logic                       exp_empty;

  int   errors = 0;
  int   checks = 0;
  int   test_errors;
  int   drain_cycles;
  logic seen_full;

  mshr_top uut (
    .clock       (clock),
    .reset       (reset),
    .miss        (miss),
    .mem_rsp     (mem_rsp),
    .search_req  (search_req),
    .fill_accept (fill_accept),
    .ready       (ready),
    .mem_req     (mem_req),
    .fill        (fill),
    .search_rsp  (search_rsp),
    .empty       (empty)
  );

  // memory responder plus reference queue
  tb_mshr_model model (
    .clock       (clock),
    .reset       (reset),
    .miss        (miss),
    .mem_req     (mem_req),
    .fill_accept (fill_accept),
    .search_req  (search_req),
    .mem_rsp     (mem_rsp),
    .exp_req     (exp_req),
    .exp_fill    (exp_fill),
    .exp_search  (exp_search),
    .exp_ready   (exp_ready),
    .exp_empty   (exp_empty)
  );

  always #(period / 2) clock = ~clock;

  task automatic check_req(input mem_req_t exp, input mem_req_t got);
    checks++;
    if ((exp.command == bus_none) ? (got.command !== bus_none) : (got !== exp)) begin
      $display("MISMATCH t=%0t mem_req exp=%h got=%h", $time, exp, got);
      errors++;
    end
  endtask

  task automatic check_fill(input fill_t exp, input fill_t got);
    checks++;
    if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
      $display("MISMATCH t=%0t fill exp=%h got=%h", $time, exp, got);
      errors++;
    end
  endtask

  task automatic check_search(input search_rsp_t exp, input search_rsp_t got);
    checks++;
    if (got.hit !== exp.hit || got.forward !== exp.forward ||
        (exp.forward && got.data !== exp.data)) begin
      $display("MISMATCH t=%0t search_rsp exp=%h got=%h", $time, exp, got);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s exp=%b got=%b", $time, name, exp, got);
      errors++;
    end
  endtask

  // small pool so that lines repeat and searches hit
  function automatic mshr_addr_t pick_addr();
    return mshr_addr_t'(32'h0000_4000 + ($urandom % 6) * 64);
  endfunction

  function automatic miss_req_t random_miss();
    miss_req_t m;
    m.en      = 1'b1;
    m.addr    = pick_addr();
    m.data    = {$urandom, $urandom};
    m.command = ($urandom % 2) ? bus_load : bus_store;
    return m;
  endfunction

  task automatic run_cycle(input logic allow_misses, input int accept_pct);
    @(negedge clock);
    miss = '0;
    if (allow_misses && ready) begin
      for (int l = 0; l < mshr_lanes; l++) begin
        if ($urandom % 2) miss[l] = random_miss();
      end
    end
    fill_accept     = ($urandom % 100) < accept_pct;
    search_req.en   = ($urandom % 4) != 0;
    search_req.addr = pick_addr();
    // outputs are stable well before the next rising edge
    #(period / 10);
    if (!ready) seen_full = 1'b1;
    check_req(exp_req, mem_req);
    check_fill(exp_fill, fill);
    check_search(exp_search, search_rsp);
    check_flag("ready", exp_ready, ready);
    check_flag("empty", exp_empty, empty);
  endtask

  task automatic finish_test(input string name);
    $display("test %-8s %s, %0d errors", name, (errors == test_errors) ? "ok" : "FAILED",
             errors - test_errors);
    test_errors = errors;
  endtask

  initial begin
    void'($urandom(32'h7df1));
    clock       = 1'b0;
    reset       = 1'b1;
    miss        = '0;
    search_req  = '0;
    fill_accept = 1'b0;
    test_errors = 0;
    seen_full   = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    #(period / 10);
    check_flag("ready", 1'b1, ready);
    check_flag("empty", 1'b1, empty);
    check_req('0, mem_req);
    check_fill('0, fill);
    finish_test("reset");

    repeat (traffic_cycles) run_cycle(1'b1, 70);
    finish_test("traffic");

    // fills held back until the queue backs up
    seen_full = 1'b0;
    repeat (stall_cycles) run_cycle(1'b1, 0);
    if (!seen_full) begin
      $display("ready never fell while fills were held back");
      errors++;
    end
    finish_test("capacity");

    drain_cycles = 0;
    while (!empty && drain_cycles < drain_limit) begin
      run_cycle(1'b0, 100);
      drain_cycles++;
    end
    if (!empty) begin
      $display("queue still holds entries after %0d drain cycles", drain_limit);
      errors++;
    end
    finish_test("drain");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(total_cycles * 4 * period);
    $display("timeout after %0d clock periods", total_cycles * 4);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* mshr.f */
mshr_cfg_pkg.sv
mshr_types_pkg.sv
mshr_entry_table.sv
mshr_alloc.sv
mshr_issue.sv
mshr_search.sv
mshr_retire.sv
mshr_top.sv
tb_mshr_model.sv
tb_mshr.sv
